// ==== pod_top.f ====
+incdir+testbench
source/pod_pkg.sv
source/pod_tag_client.sv
source/pod_link_fifo.sv
source/pod_tile.sv
source/pod_top.sv
testbench/pod_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the pod testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f pod_top.f --top-module pod_tb -o pod_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/pod_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0

// ==== testbench/pod_tb_vectors.svh ====
`ifndef POD_TB_VECTORS_SVH
`define POD_TB_VECTORS_SVH

// one request per entry
typedef struct packed {
  logic [1:0] col;
  pod_pkt_s   pkt;
  logic       rsp;
  logic       south;
  data_t      data;
} vec_s;

// entries [0, T2_END) tag check, [T2_END, T3_END) tiles, the rest pass-through
localparam int T2_END   = 2;
localparam int T3_END   = 16;
localparam int NUM_VECS = 20;

// col, {op, dest_y, addr, data}, response expected, south exit expected, load data
localparam vec_s VECS [NUM_VECS] = '{
  '{2'd0, '{OP_STORE, 4'd5, 4'd0, 32'h5a5a_0001}, 1'b0, 1'b0, 32'h0000_0000},
  '{2'd0, '{OP_LOAD,  4'd5, 4'd0, 32'h0000_0000}, 1'b1, 1'b0, 32'h5a5a_0001},
  '{2'd0, '{OP_STORE, 4'd6, 4'd1, 32'h1111_0006}, 1'b0, 1'b0, 32'h0000_0000},
  '{2'd0, '{OP_STORE, 4'd7, 4'd2, 32'h2222_0007}, 1'b0, 1'b0, 32'h0000_0000},
  '{2'd1, '{OP_STORE, 4'd5, 4'd0, 32'h3333_1005}, 1'b0, 1'b0, 32'h0000_0000},
  '{2'd1, '{OP_STORE, 4'd6, 4'd1, 32'h4444_1006}, 1'b0, 1'b0, 32'h0000_0000},
  '{2'd1, '{OP_STORE, 4'd7, 4'd2, 32'h5555_1007}, 1'b0, 1'b0, 32'h0000_0000},
  // overwrite, the load must see the newer value
  '{2'd0, '{OP_STORE, 4'd7, 4'd2, 32'h6666_0007}, 1'b0, 1'b0, 32'h0000_0000},
  '{2'd0, '{OP_LOAD,  4'd6, 4'd1, 32'h0000_0000}, 1'b1, 1'b0, 32'h1111_0006},
  '{2'd0, '{OP_LOAD,  4'd7, 4'd2, 32'h0000_0000}, 1'b1, 1'b0, 32'h6666_0007},
  '{2'd1, '{OP_LOAD,  4'd7, 4'd2, 32'h0000_0000}, 1'b1, 1'b0, 32'h5555_1007},
  '{2'd1, '{OP_LOAD,  4'd5, 4'd0, 32'h0000_0000}, 1'b1, 1'b0, 32'h3333_1005},
  '{2'd1, '{OP_LOAD,  4'd6, 4'd1, 32'h0000_0000}, 1'b1, 1'b0, 32'h4444_1006},
  '{2'd0, '{OP_STORE, 4'd5, 4'hf, 32'h7777_000f}, 1'b0, 1'b0, 32'h0000_0000},
  '{2'd0, '{OP_LOAD,  4'd5, 4'hf, 32'h0000_0000}, 1'b1, 1'b0, 32'h7777_000f},
  '{2'd0, '{OP_LOAD,  4'd5, 4'd0, 32'h0000_0000}, 1'b1, 1'b0, 32'h5a5a_0001},
  // outside the rows of the pod
  '{2'd0, '{OP_STORE, 4'd3, 4'd4, 32'hdead_0003}, 1'b0, 1'b1, 32'h0000_0000},
  '{2'd1, '{OP_LOAD,  4'd8, 4'd5, 32'h0000_0000}, 1'b0, 1'b1, 32'h0000_0000},
  '{2'd0, '{OP_LOAD,  4'hf, 4'd1, 32'h0000_0000}, 1'b0, 1'b1, 32'h0000_0000},
  '{2'd1, '{OP_STORE, 4'd4, 4'd7, 32'hbeef_0004}, 1'b0, 1'b1, 32'h0000_0000}
};

`endif

// ==== testbench/pod_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pod_tb;

  import pod_pkg::*;

  localparam int NX      = 2;
  localparam int NY      = 3;
  localparam int TIMEOUT = 1000;

  `include "pod_tb_vectors.svh"

  typedef struct packed {
    logic [1:0] col;
    pod_rsp_s   rsp;
  } rsp_exp_s;

  typedef struct packed {
    logic [1:0] col;
    pod_pkt_s   pkt;
  } south_exp_s;

  logic       clk_i;
  logic       arst_n_i;
  pod_tag_s   tag_i;
  logic       req_valid_i       [NX];
  pod_pkt_s   req_i             [NX];
  logic       req_ready_o       [NX];
  logic       rsp_valid_o       [NX];
  pod_rsp_s   rsp_o             [NX];
  logic       rsp_ready_i       [NX];
  logic       south_req_valid_o [NX];
  pod_pkt_s   south_req_o       [NX];
  logic       south_req_ready_i [NX];

  rsp_exp_s   rsp_q   [$];
  south_exp_s south_q [$];
  data_t      model_mem [NX][16][16];
  coord_t     cur_origin;
  integer     seed;
  int         err_cnt;
  int         test_num;
  int         test_fail;
  int         test_err_start;
  bit         aborted;
  bit         done;
  bit         stall_en;

  pod_top #(
    .NUM_TILES_X_P(NX),
    .NUM_TILES_Y_P(NY),
    .RESET_DEPTH_P(3),
    .DMEM_WORDS_P (16)
  ) UUT (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .tag_i            (tag_i),
    .req_valid_i      (req_valid_i),
    .req_i            (req_i),
    .req_ready_o      (req_ready_o),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_o            (rsp_o),
    .rsp_ready_i      (rsp_ready_i),
    .south_req_valid_o(south_req_valid_o),
    .south_req_o      (south_req_o),
    .south_req_ready_i(south_req_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("timeout while waiting for %s", what);
    err_cnt++;
    aborted = 1'b1;
  endtask

  // start bit, then reset bit and origin_y lsb first
  task automatic send_tag_frame(input logic rst_bit, input coord_t origin);
    logic [TAG_PAYLOAD_W-1:0] payload;
    payload = {origin, rst_bit};
    tag_i <= '{valid: 1'b1, data: 1'b1};
    @(posedge clk_i);
    for (int i = 0; i < TAG_PAYLOAD_W; i++) begin
      tag_i <= '{valid: 1'b1, data: payload[i]};
      @(posedge clk_i);
      // idle slot inside the frame
      if (i == 1) begin
        tag_i <= '0;
        @(posedge clk_i);
      end
    end
    tag_i <= '0;
  endtask

  task automatic wait_req_ready(input logic level);
    int n;
    for (int c = 0; c < NX; c++) begin
      n = 0;
      while (req_ready_o[c] !== level && n < TIMEOUT && !aborted) begin
        @(posedge clk_i);
        n++;
      end
      if (n >= TIMEOUT) begin
        note_timeout("req_ready_o to change");
      end
    end
  endtask

  task automatic send_request(input int col, input pod_pkt_s pkt);
    int n;
    req_valid_i[col] <= 1'b1;
    req_i[col]       <= pkt;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!req_ready_o[col] && n < TIMEOUT && !aborted);
    req_valid_i[col] <= 1'b0;
    if (!req_ready_o[col] && !aborted) begin
      note_timeout("a request to be accepted");
    end
  endtask

  // reference model of row mapping and memory per column and global y
  task automatic apply_request(input int col, input pod_pkt_s pkt, output logic rsp_f,
                               output logic south_f, output data_t exp_d);
    coord_t     rel;
    rsp_exp_s   re;
    south_exp_s se;
    rel     = pkt.dest_y - cur_origin;
    rsp_f   = 1'b0;
    south_f = 1'b0;
    exp_d   = '0;
    if (rel >= coord_t'(NY)) begin
      south_f = 1'b1;
      se.col  = 2'(col);
      se.pkt  = pkt;
      south_q.push_back(se);
    end else if (pkt.op == OP_STORE) begin
      model_mem[col][pkt.dest_y][pkt.addr] = pkt.data;
    end else begin
      rsp_f        = 1'b1;
      exp_d        = model_mem[col][pkt.dest_y][pkt.addr];
      re.col       = 2'(col);
      re.rsp.src_y = pkt.dest_y;
      re.rsp.addr  = pkt.addr;
      re.rsp.data  = exp_d;
      rsp_q.push_back(re);
    end
    send_request(col, pkt);
  endtask

  task automatic apply_vector(input int idx);
    vec_s  v;
    logic  rsp_f;
    logic  south_f;
    data_t exp_d;
    v = VECS[idx];
    apply_request(int'(v.col), v.pkt, rsp_f, south_f, exp_d);
    compare_value("table rsp flag", 64'(v.rsp), 64'(rsp_f));
    compare_value("table south flag", 64'(v.south), 64'(south_f));
    if (rsp_f) begin
      compare_value("table load data", 64'(v.data), 64'(exp_d));
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((rsp_q.size() != 0 || south_q.size() != 0) && n < TIMEOUT && !aborted) begin
      @(posedge clk_i);
      n++;
    end
    if (n >= TIMEOUT) begin
      note_timeout("the last responses and south exits");
    end
  endtask

  task automatic run_vectors(input int first, input int last);
    for (int i = first; i < last; i++) begin
      apply_vector(i);
    end
    wait_drain();
  endtask

  task automatic end_test(input string name);
    test_num++;
    if (err_cnt != test_err_start) begin
      test_fail++;
    end
    $display("test %0d %s: %s", test_num, name, (err_cnt == test_err_start) ? "ok" : "failed");
    test_err_start = err_cnt;
  endtask

  task automatic run_reorigin();
    pod_pkt_s pkt;
    logic     rsp_f;
    logic     south_f;
    data_t    exp_d;
    send_tag_frame(1'b1, 4'd2);
    wait_req_ready(1'b0);
    send_tag_frame(1'b0, 4'd2);
    cur_origin = 4'd2;
    wait_req_ready(1'b1);
    // y 1 and y 5 now lie outside the pod
    for (int op = 0; op < 2; op++) begin
      for (int c = 0; c < NX; c++) begin
        for (int y = 1; y <= 5; y++) begin
          pkt.op     = (op == 0) ? OP_STORE : OP_LOAD;
          pkt.dest_y = coord_t'(y);
          pkt.addr   = addr_t'(3 * y + c);
          pkt.data   = 32'hc0de_0000 + data_t'(16 * c + y);
          apply_request(c, pkt, rsp_f, south_f, exp_d);
        end
      end
    end
    wait_drain();
  endtask

  task automatic monitor_outputs();
    int idx;
    while (!done) begin
      @(posedge clk_i);
      for (int c = 0; c < NX; c++) begin
        if (rsp_valid_o[c] && rsp_ready_i[c]) begin
          idx = -1;
          for (int i = 0; i < rsp_q.size(); i++) begin
            if (idx < 0 && rsp_q[i].col == 2'(c) && rsp_q[i].rsp.src_y == rsp_o[c].src_y) begin
              idx = i;
            end
          end
          if (idx < 0) begin
            $display("unexpected response on column %0d from y %0d", c, rsp_o[c].src_y);
            err_cnt++;
          end else begin
            compare_value("rsp_o.addr", 64'(rsp_q[idx].rsp.addr), 64'(rsp_o[c].addr));
            compare_value("rsp_o.data", 64'(rsp_q[idx].rsp.data), 64'(rsp_o[c].data));
            rsp_q.delete(idx);
          end
        end
        if (south_req_valid_o[c] && south_req_ready_i[c]) begin
          idx = -1;
          for (int i = 0; i < south_q.size(); i++) begin
            if (idx < 0 && south_q[i].col == 2'(c)) begin
              idx = i;
            end
          end
          if (idx < 0) begin
            $display("unexpected request leaving the south edge of column %0d", c);
            err_cnt++;
          end else begin
            compare_value("south_req_o", 64'(south_q[idx].pkt), 64'(south_req_o[c]));
            south_q.delete(idx);
          end
        end
      end
    end
  endtask

  // random low periods on the host readies
  task automatic drive_ready();
    logic [31:0] rnd;
    while (!done) begin
      @(posedge clk_i);
      for (int c = 0; c < NX; c++) begin
        rnd = $random(seed);
        rsp_ready_i[c]       <= !stall_en || (rnd[1:0] != 2'b00);
        south_req_ready_i[c] <= !stall_en || (rnd[3:2] != 2'b00);
      end
    end
  endtask

  task automatic run_tests();
    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;
    repeat (50) begin
      @(posedge clk_i);
      for (int c = 0; c < NX; c++) begin
        compare_value("req_ready_o", 64'(0), 64'(req_ready_o[c]));
      end
    end
    end_test("reset hold");
    send_tag_frame(1'b0, 4'd5);
    cur_origin = 4'd5;
    wait_req_ready(1'b1);
    run_vectors(0, T2_END);
    end_test("tag programming");
    run_vectors(T2_END, T3_END);
    end_test("store and load per tile");
    run_vectors(T3_END, NUM_VECS);
    end_test("pass-through");
    stall_en = 1'b1;
    run_vectors(0, NUM_VECS);
    stall_en = 1'b0;
    end_test("back-pressure");
    run_reorigin();
    // late duplicates would show up here
    repeat (20) @(posedge clk_i);
    end_test("re-origin");
    done = 1'b1;
  endtask

  initial begin
    seed           = 32'h019b0e1b;
    err_cnt        = 0;
    test_num       = 0;
    test_fail      = 0;
    test_err_start = 0;
    aborted        = 1'b0;
    done           = 1'b0;
    stall_en       = 1'b0;
    cur_origin     = '0;
    arst_n_i <= 1'b0;
    tag_i    <= '0;
    for (int c = 0; c < NX; c++) begin
      req_valid_i[c]       <= 1'b0;
      req_i[c]             <= '0;
      rsp_ready_i[c]       <= 1'b1;
      south_req_ready_i[c] <= 1'b1;
    end
    fork
      run_tests();
      monitor_outputs();
      drive_ready();
    join
    $display("tests %0d, failed %0d, errors %0d", test_num, test_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/pod_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pod_top #(
  parameter int NUM_TILES_X_P = 2,
  parameter int NUM_TILES_Y_P = 3,
  parameter int RESET_DEPTH_P = 3,
  parameter int DMEM_WORDS_P  = 16
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  pod_pkg::pod_tag_s tag_i,
  input  logic              req_valid_i       [NUM_TILES_X_P],
  input  pod_pkg::pod_pkt_s req_i             [NUM_TILES_X_P],
  output logic              req_ready_o       [NUM_TILES_X_P],
  output logic              rsp_valid_o       [NUM_TILES_X_P],
  output pod_pkg::pod_rsp_s rsp_o             [NUM_TILES_X_P],
  input  logic              rsp_ready_i       [NUM_TILES_X_P],
  output logic              south_req_valid_o [NUM_TILES_X_P],
  output pod_pkg::pod_pkt_s south_req_o       [NUM_TILES_X_P],
  input  logic              south_req_ready_i [NUM_TILES_X_P]
);

  import pod_pkg::*;

  logic   pod_reset;
  coord_t origin_y;

  pod_tag_client #(.RESET_DEPTH_P(RESET_DEPTH_P)) tag_client (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .tag_i     (tag_i),
    .reset_o   (pod_reset),
    .origin_y_o(origin_y)
  );

  // _li enters a tile, _lo leaves it
  logic     reset_li   [NUM_TILES_Y_P][NUM_TILES_X_P];
  logic     reset_lo   [NUM_TILES_Y_P][NUM_TILES_X_P];
  coord_t   y_li       [NUM_TILES_Y_P][NUM_TILES_X_P];
  coord_t   y_lo       [NUM_TILES_Y_P][NUM_TILES_X_P];
  logic     req_vld_li [NUM_TILES_Y_P][NUM_TILES_X_P];
  logic     req_vld_lo [NUM_TILES_Y_P][NUM_TILES_X_P];
  pod_pkt_s req_li     [NUM_TILES_Y_P][NUM_TILES_X_P];
  pod_pkt_s req_lo     [NUM_TILES_Y_P][NUM_TILES_X_P];
  logic     req_rdy_li [NUM_TILES_Y_P][NUM_TILES_X_P];
  logic     req_rdy_lo [NUM_TILES_Y_P][NUM_TILES_X_P];
  logic     rsp_vld_li [NUM_TILES_Y_P][NUM_TILES_X_P];
  logic     rsp_vld_lo [NUM_TILES_Y_P][NUM_TILES_X_P];
  pod_rsp_s rsp_li     [NUM_TILES_Y_P][NUM_TILES_X_P];
  pod_rsp_s rsp_lo     [NUM_TILES_Y_P][NUM_TILES_X_P];
  logic     rsp_rdy_li [NUM_TILES_Y_P][NUM_TILES_X_P];
  logic     rsp_rdy_lo [NUM_TILES_Y_P][NUM_TILES_X_P];

  for (genvar y = 0; y < NUM_TILES_Y_P; y++) begin : g_row
    for (genvar x = 0; x < NUM_TILES_X_P; x++) begin : g_col
      pod_tile #(.DMEM_WORDS_P(DMEM_WORDS_P)) tile (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .reset_i    (reset_li[y][x]),
        .reset_o    (reset_lo[y][x]),
        .y_i        (y_li[y][x]),
        .y_o        (y_lo[y][x]),
        .req_valid_i(req_vld_li[y][x]),
        .req_i      (req_li[y][x]),
        .req_ready_o(req_rdy_lo[y][x]),
        .req_valid_o(req_vld_lo[y][x]),
        .req_o      (req_lo[y][x]),
        .req_ready_i(req_rdy_li[y][x]),
        .rsp_valid_i(rsp_vld_li[y][x]),
        .rsp_i      (rsp_li[y][x]),
        .rsp_ready_o(rsp_rdy_lo[y][x]),
        .rsp_valid_o(rsp_vld_lo[y][x]),
        .rsp_o      (rsp_lo[y][x]),
        .rsp_ready_i(rsp_rdy_li[y][x])
      );

      // north side
      if (y == 0) begin : g_north_edge
        assign reset_li[y][x]   = pod_reset;
        assign y_li[y][x]       = origin_y;
        assign req_vld_li[y][x] = req_valid_i[x];
        assign req_li[y][x]     = req_i[x];
        assign req_ready_o[x]   = req_rdy_lo[y][x];
        assign rsp_valid_o[x]   = rsp_vld_lo[y][x];
        assign rsp_o[x]         = rsp_lo[y][x];
        assign rsp_rdy_li[y][x] = rsp_ready_i[x];
      end else begin : g_north_tile
        assign reset_li[y][x]   = reset_lo[y-1][x];
        assign y_li[y][x]       = y_lo[y-1][x];
        assign req_vld_li[y][x] = req_vld_lo[y-1][x];
        assign req_li[y][x]     = req_lo[y-1][x];
        assign rsp_rdy_li[y][x] = rsp_rdy_lo[y-1][x];
      end

      // south side, bottom row has no response source
      if (y == NUM_TILES_Y_P - 1) begin : g_south_edge
        assign south_req_valid_o[x] = req_vld_lo[y][x];
        assign south_req_o[x]       = req_lo[y][x];
        assign req_rdy_li[y][x]     = south_req_ready_i[x];
        assign rsp_vld_li[y][x]     = 1'b0;
        assign rsp_li[y][x]         = '0;
      end else begin : g_south_tile
        assign req_rdy_li[y][x] = req_rdy_lo[y+1][x];
        assign rsp_vld_li[y][x] = rsp_vld_lo[y+1][x];
        assign rsp_li[y][x]     = rsp_lo[y+1][x];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/pod_tile.sv ====
`timescale 1ns/1ps
`default_nettype none

module pod_tile #(
  parameter int DMEM_WORDS_P = 16
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              reset_i,
  output logic              reset_o,
  input  pod_pkg::coord_t   y_i,
  output pod_pkg::coord_t   y_o,
  input  logic              req_valid_i,
  input  pod_pkg::pod_pkt_s req_i,
  output logic              req_ready_o,
  output logic              req_valid_o,
  output pod_pkg::pod_pkt_s req_o,
  input  logic              req_ready_i,
  input  logic              rsp_valid_i,
  input  pod_pkg::pod_rsp_s rsp_i,
  output logic              rsp_ready_o,
  output logic              rsp_valid_o,
  output pod_pkg::pod_rsp_s rsp_o,
  input  logic              rsp_ready_i
);

  import pod_pkg::*;

  if (DMEM_WORDS_P > 2 ** ADDR_W) begin : g_dmem_check
    $error("DMEM_WORDS_P exceeds the address range");
  end

  logic     reset_r;
  coord_t   y_r;
  logic     req_fifo_ready;
  logic     head_valid;
  pod_pkt_s head;
  logic     head_local;
  logic     head_pop;
  logic     store_pop;
  logic     load_pop;
  logic     fwd_pop;
  logic     sreq_vld_r;
  pod_pkt_s sreq_r;
  logic     sreq_free;
  data_t    dmem_r [DMEM_WORDS_P];
  logic     lrsp_vld_r;
  pod_rsp_s lrsp_r;
  logic     rsp_fifo_ready;
  logic     srsp_valid;
  pod_rsp_s srsp;
  logic     srsp_pop;
  logic     sel_local;
  logic     hold_south_r;

  // reset and row coordinate hand-down
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reset_r <= 1'b1;
      y_r     <= '0;
    end else begin
      reset_r <= reset_i;
      y_r     <= y_i;
    end
  end

  assign reset_o = reset_r;
  assign y_o     = y_r + coord_t'(1);

  pod_link_fifo #(.T_P(pod_pkt_s)) req_fifo (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .valid_i (req_valid_i && !reset_r),
    .data_i  (req_i),
    .ready_o (req_fifo_ready),
    .valid_o (head_valid),
    .data_o  (head),
    .ready_i (head_pop)
  );

  assign req_ready_o = req_fifo_ready && !reset_r;

  // head decode
  assign head_local = (head.dest_y == y_r);
  assign sreq_free  = !sreq_vld_r || req_ready_i;
  assign store_pop  = head_valid && !reset_r && head_local && (head.op == OP_STORE);
  assign load_pop   = head_valid && !reset_r && head_local && (head.op == OP_LOAD)
                      && !lrsp_vld_r;
  assign fwd_pop    = head_valid && !reset_r && !head_local && sreq_free;
  assign head_pop   = store_pop || load_pop || fwd_pop;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sreq_vld_r   <= 1'b0;
      lrsp_vld_r   <= 1'b0;
      hold_south_r <= 1'b0;
    end else if (reset_r) begin
      sreq_vld_r   <= 1'b0;
      lrsp_vld_r   <= 1'b0;
      hold_south_r <= 1'b0;
    end else begin
      if (fwd_pop) begin
        sreq_vld_r <= 1'b1;
      end else if (req_ready_i) begin
        sreq_vld_r <= 1'b0;
      end
      if (load_pop) begin
        lrsp_vld_r <= 1'b1;
      end else if (rsp_ready_i && sel_local) begin
        lrsp_vld_r <= 1'b0;
      end
      // keep offering a south response once it is on the port
      hold_south_r <= srsp_valid && !sel_local && !rsp_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fwd_pop) begin
      sreq_r <= head;
    end
    if (store_pop) begin
      dmem_r[head.addr] <= head.data;
    end
    if (load_pop) begin
      lrsp_r.src_y <= y_r;
      lrsp_r.addr  <= head.addr;
      lrsp_r.data  <= dmem_r[head.addr];
    end
  end

  assign req_valid_o = sreq_vld_r && !reset_r;
  assign req_o       = sreq_r;

  pod_link_fifo #(.T_P(pod_rsp_s)) rsp_fifo (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .valid_i (rsp_valid_i && !reset_r),
    .data_i  (rsp_i),
    .ready_o (rsp_fifo_ready),
    .valid_o (srsp_valid),
    .data_o  (srsp),
    .ready_i (srsp_pop)
  );

  assign rsp_ready_o = rsp_fifo_ready && !reset_r;

  // local response first
  assign sel_local   = lrsp_vld_r && !hold_south_r;
  assign rsp_valid_o = !reset_r && (lrsp_vld_r || srsp_valid);
  assign rsp_o       = sel_local ? lrsp_r : srsp;
  assign srsp_pop    = rsp_ready_i && !reset_r && !sel_local && srsp_valid;

  // an offered response holds until it is taken
  a_rsp_hold: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (rsp_valid_o && !rsp_ready_i && !reset_i) |=> (rsp_valid_o && $stable(rsp_o))
  );

endmodule

`default_nettype wire

// ==== source/pod_link_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module pod_link_fifo #(
  parameter type T_P = logic
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic valid_i,
  input  T_P   data_i,
  output logic ready_o,
  output logic valid_o,
  output T_P   data_o,
  input  logic ready_i
);

  T_P         mem_r [2];
  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;
  logic [1:0] count_n;
  logic       ready_r;
  logic       push;
  logic       pop;

  assign push = valid_i && ready_r;
  assign pop  = valid_o && ready_i;

  always_comb begin
    count_n = count_r;
    if (push && !pop) begin
      count_n = count_r + 2'd1;
    end else if (pop && !push) begin
      count_n = count_r - 2'd1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= '0;
      ready_r  <= 1'b1;
    end else begin
      wr_ptr_r <= wr_ptr_r ^ push;
      rd_ptr_r <= rd_ptr_r ^ pop;
      count_r  <= count_n;
      ready_r  <= (count_n != 2'd2);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  assign ready_o = ready_r;
  assign valid_o = (count_r != 2'd0);
  assign data_o  = mem_r[rd_ptr_r];

  // full means both pointers on the same occupied entry
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    push |-> !(valid_o && (wr_ptr_r == rd_ptr_r))
  );

endmodule

`default_nettype wire

// ==== source/pod_tag_client.sv ====
`timescale 1ns/1ps
`default_nettype none

module pod_tag_client #(
  parameter int RESET_DEPTH_P = 3
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  pod_pkg::pod_tag_s tag_i,
  output logic              reset_o,
  output pod_pkg::coord_t   origin_y_o
);

  import pod_pkg::*;

  localparam int CNT_W = $clog2(TAG_PAYLOAD_W);

  tag_state_e               state_r;
  tag_state_e               state_n;
  logic [CNT_W-1:0]         cnt_r;
  logic [TAG_PAYLOAD_W-1:0] shift_r;
  logic [TAG_PAYLOAD_W-1:0] payload_r;
  logic [RESET_DEPTH_P-1:0] rst_pipe_r;
  logic                     last_bit;

  assign last_bit = tag_i.valid && (cnt_r == CNT_W'(TAG_PAYLOAD_W - 1));

  always_comb begin
    state_n = state_r;
    case (state_r)
      TAG_IDLE: begin
        if (tag_i.valid && tag_i.data) begin
          state_n = TAG_SHIFT;
        end
      end
      TAG_SHIFT: begin
        if (last_bit) begin
          state_n = TAG_COMMIT;
        end
      end
      default: state_n = TAG_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= TAG_IDLE;
      cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      if (state_r == TAG_IDLE) begin
        cnt_r <= '0;
      end else if (state_r == TAG_SHIFT && tag_i.valid) begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
  end

  // payload shifts in from the top, first bit ends in bit 0
  always_ff @(posedge clk_i) begin
    if (state_r == TAG_SHIFT && tag_i.valid) begin
      shift_r <= {tag_i.data, shift_r[TAG_PAYLOAD_W-1:1]};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      payload_r  <= {COORD_W'(0), 1'b1};
      rst_pipe_r <= '1;
    end else begin
      if (state_r == TAG_COMMIT) begin
        payload_r <= shift_r;
      end
      rst_pipe_r <= (rst_pipe_r << 1) | RESET_DEPTH_P'(payload_r[0]);
    end
  end

  assign reset_o    = rst_pipe_r[RESET_DEPTH_P-1];
  assign origin_y_o = payload_r[TAG_PAYLOAD_W-1:1];

  // reset only moves as the delayed image of a commit
  a_reset_after_commit: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $changed(reset_o) |-> $past(state_r == TAG_COMMIT, RESET_DEPTH_P + 1)
  );

endmodule

`default_nettype wire

// ==== source/pod_pkg.sv ====
`default_nettype none

package pod_pkg;

  // field widths
  localparam int COORD_W = 4;
  localparam int ADDR_W  = 4;
  localparam int DATA_W  = 32;

  typedef logic [COORD_W-1:0] coord_t;
  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DATA_W-1:0]  data_t;

  typedef enum logic {
    OP_STORE = 1'b0,
    OP_LOAD  = 1'b1
  } pod_op_e;

  // request travelling south
  typedef struct packed {
    pod_op_e op;
    coord_t  dest_y;
    addr_t   addr;
    data_t   data;
  } pod_pkt_s;

  // load response travelling north
  typedef struct packed {
    coord_t src_y;
    addr_t  addr;
    data_t  data;
  } pod_rsp_s;

  // serial tag bus, one bit per cycle
  typedef struct packed {
    logic valid;
    logic data;
  } pod_tag_s;

  // reset bit first, then origin_y lsb first
  localparam int TAG_PAYLOAD_W = 1 + COORD_W;

  typedef enum logic [1:0] {
    TAG_IDLE   = 2'd0,
    TAG_SHIFT  = 2'd1,
    TAG_COMMIT = 2'd2
  } tag_state_e;

endpackage

`default_nettype wire
